//--- Makefile
# Verilator build and run for the APB line cache testbench
# A failing run ends in $fatal, so the run target returns a failing status

SRCS := $(shell grep '\.sv$$' project.f)

.PHONY: all run clean

all: obj_dir/Vcache_tb

obj_dir/Vcache_tb: project.f $(SRCS)
	verilator --binary --timing -j 0 --top-module cache_tb \
		--Mdir obj_dir -o Vcache_tb -f project.f

run: obj_dir/Vcache_tb
	./obj_dir/Vcache_tb

clean:
	rm -rf obj_dir

//--- design/cache_ctrl.sv
// APB slave front end of the line cache with one wait state per transfer
// Decodes line and CSR space, scrambles data and keeps hit and miss counts
`timescale 1ns/10ps

module cache_ctrl import cache_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [addr_w-1:0] paddr,
    input  cache_data_t       pwdata,
    input  logic              st_hit,
    input  cache_data_t       st_rdata,
    input  cache_data_t       mask,
    output cache_data_t       prdata,
    output logic              pready,
    output logic              pslverr,
    output cache_index_t      st_index,
    output cache_tag_t        st_tag,
    output cache_data_t       st_wdata,
    output logic              st_write,
    output logic              st_flush,
    output cache_index_t      mask_index
);

    localparam logic [1:0] state_idle     = 2'd0;
    localparam logic [1:0] state_access   = 2'd1;  // First access cycle, pready low
    localparam logic [1:0] state_complete = 2'd2;  // Second access cycle, pready high

    logic [1:0]  state;
    apb_addr_u   addr;
    logic        in_access;
    logic        is_line;
    logic        line_rd;
    cache_data_t resp_data;
    logic        resp_err;
    cache_data_t hit_cnt;
    cache_data_t miss_cnt;

    assign addr      = paddr;
    assign in_access = (state == state_access);
    assign is_line   = (addr.line.space == space_line);
    assign line_rd   = in_access && is_line && !pwrite;

    // Store and scrambler see the decoded line address directly
    assign st_index   = addr.line.index;
    assign st_tag     = addr.line.tag;
    assign mask_index = addr.line.index;
    assign st_wdata   = pwdata ^ mask;  // Scramble on the way in
    assign st_write   = in_access && is_line && pwrite;
    assign st_flush   = in_access && !is_line && pwrite && (addr.csr.sel == csr_flush);

    // Response for the current access
    always_comb begin
        resp_data = '0;
        resp_err  = 1'b0;
        if (is_line) begin
            if (!pwrite) begin
                if (st_hit) begin
                    resp_data = st_rdata ^ mask;  // Unscramble
                end else begin
                    resp_err = 1'b1;  // Read miss
                end
            end
        end else begin
            case (addr.csr.sel)
                csr_flush:  resp_data = '0;
                csr_hits:   resp_data = pwrite ? '0 : hit_cnt;
                csr_misses: resp_data = pwrite ? '0 : miss_cnt;
                default:    resp_err  = 1'b1;  // Undefined CSR
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= state_idle;
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            case (state)
                state_idle: begin
                    if (psel && !penable) begin  // Setup phase seen
                        state <= state_access;
                    end
                end
                state_access: begin
                    pready  <= 1'b1;
                    pslverr <= resp_err;
                    state   <= state_complete;
                end
                state_complete: begin
                    pready  <= 1'b0;
                    pslverr <= 1'b0;
                    state   <= state_idle;
                end
                default: state <= state_idle;
            endcase
        end
    end

    // Read data held through the complete cycle
    always_ff @(posedge clk) begin
        if (in_access) begin
            prdata <= resp_data;
        end
    end

    // Saturating counters, line-space reads only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit_cnt  <= '0;
            miss_cnt <= '0;
        end else if (line_rd) begin
            if (st_hit && hit_cnt != '1) begin
                hit_cnt <= hit_cnt + 1'b1;
            end else if (!st_hit && miss_cnt != '1) begin
                miss_cnt <= miss_cnt + 1'b1;
            end
        end
    end

endmodule

//--- design/cache_pkg.sv
// Shared widths, CSR map and APB address layout for the line cache
// Imported by every design module and by the testbench
package cache_pkg;

    localparam int data_w  = 16;  // Line data width
    localparam int tag_w   = 4;
    localparam int index_w = 3;   // 8 lines
    localparam int addr_w  = 12;  // APB address width
    localparam int key_w   = 128; // Scrambler key seed width

    typedef logic [data_w-1:0]  cache_data_t;
    typedef logic [tag_w-1:0]   cache_tag_t;
    typedef logic [index_w-1:0] cache_index_t;

    // One address word, read as a line access or as a CSR access
    typedef union packed {
        struct packed {
            logic         space;
            logic [2:0]   rsvd;
            cache_tag_t   tag;
            cache_index_t index;
            logic         low;  // Halfword offset, ignored
        } line;
        struct packed {
            logic       space;
            logic [8:0] rsvd;
            logic [1:0] sel;
        } csr;
    } apb_addr_u;

    localparam logic       space_line = 1'b0;
    localparam logic       space_csr  = 1'b1;
    localparam logic [1:0] csr_flush  = 2'd0;  // Write clears all valid bits
    localparam logic [1:0] csr_hits   = 2'd1;
    localparam logic [1:0] csr_misses = 2'd2;

endpackage

//--- design/cache_top.sv
// Top level of the APB line cache, wires controller, store and scrambler
// KEY_INIT sets the scrambler seed loaded at reset
`timescale 1ns/10ps

module cache_top import cache_pkg::*; #(
    parameter logic [key_w-1:0] KEY_INIT = 128'h0f1e_2d3c_4b5a_6978_8796_a5b4_c3d2_e1f0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [addr_w-1:0] paddr,
    input  cache_data_t       pwdata,
    output cache_data_t       prdata,
    output logic              pready,
    output logic              pslverr
);

    cache_index_t st_index;
    cache_tag_t   st_tag;
    cache_data_t  st_wdata;
    logic         st_write;
    logic         st_flush;
    logic         st_hit;
    cache_data_t  st_rdata;
    cache_index_t mask_index;
    cache_data_t  mask;

    cache_ctrl ctrl0 (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .st_hit     (st_hit),
        .st_rdata   (st_rdata),
        .mask       (mask),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .st_index   (st_index),
        .st_tag     (st_tag),
        .st_wdata   (st_wdata),
        .st_write   (st_write),
        .st_flush   (st_flush),
        .mask_index (mask_index)
    );

    line_store store0 (
        .clk      (clk),
        .rst      (rst),
        .st_index (st_index),
        .st_tag   (st_tag),
        .st_wdata (st_wdata),
        .st_write (st_write),
        .st_flush (st_flush),
        .st_hit   (st_hit),
        .st_rdata (st_rdata)
    );

    line_scrambler #(
        .KEY_INIT (KEY_INIT)
    ) scram0 (
        .clk        (clk),
        .rst        (rst),
        .mask_index (mask_index),
        .mask       (mask)
    );

endmodule

//--- design/line_scrambler.sv
// Per-line XOR mask generator for data at rest in the line store
// Mask depends only on the key seed and the line index
`timescale 1ns/10ps

module line_scrambler import cache_pkg::*; #(
    parameter logic [key_w-1:0] KEY_INIT = '0
) (
    input  logic         clk,
    input  logic         rst,
    input  cache_index_t mask_index,
    output cache_data_t  mask
);

    logic [key_w-1:0]    key_seed;
    cache_data_t         key_slice;
    logic [2*data_w-1:0] rot_pair;
    cache_data_t         rot_slice;

    // Seed is fixed after reset, no run-time reload
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_seed <= KEY_INIT;
        end else begin
            key_seed <= key_seed;
        end
    end

    // 16-bit slice picked by the index
    assign key_slice = key_seed[mask_index*data_w +: data_w];

    // Rotate left by index, upper half of the shifted pair
    assign rot_pair  = {key_slice, key_slice} << mask_index;
    assign rot_slice = rot_pair[2*data_w-1:data_w];

    // Index folded into the low bits keeps masks distinct per line
    assign mask = rot_slice ^ {{(data_w-index_w){1'b0}}, mask_index};

endmodule

//--- design/line_store.sv
// Direct-mapped storage of line data, tags and valid bits
// Lookup is combinational, fill and flush happen on the clock edge
`timescale 1ns/10ps

module line_store import cache_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  cache_index_t st_index,
    input  cache_tag_t   st_tag,
    input  cache_data_t  st_wdata,
    input  logic         st_write,
    input  logic         st_flush,
    output logic         st_hit,
    output cache_data_t  st_rdata
);

    localparam int lines = 1 << index_w;

    cache_data_t      data_mem [lines];  // Scrambled payload
    cache_tag_t       tag_mem  [lines];
    logic [lines-1:0] valid;

    // Lookup
    assign st_hit   = valid[st_index] && (tag_mem[st_index] == st_tag);
    assign st_rdata = data_mem[st_index];

    always_ff @(posedge clk) begin
        if (st_write) begin
            data_mem[st_index] <= st_wdata;
            tag_mem[st_index]  <= st_tag;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (st_flush) begin
            valid <= '0;  // Drop every line
        end else if (st_write) begin
            valid[st_index] <= 1'b1;
        end
    end

endmodule

//--- dv/cache_tb.sv
// Self-checking testbench for the APB line cache
// Builds a stimulus table from a reference model, then replays it over APB
`timescale 1ns/10ps

module cache_tb import cache_pkg::*;;

    typedef struct packed {
        logic              wr;
        logic [addr_w-1:0] addr;
        cache_data_t       wdata;
        cache_data_t       exp_data;
        logic              exp_err;
    } entry_t;

    logic              clk;
    logic              rst;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [addr_w-1:0] paddr;
    cache_data_t       pwdata;
    cache_data_t       prdata;
    logic              pready;
    logic              pslverr;

    entry_t      tbl[$];
    logic [31:0] lfsr = 32'h6ce4_d708;
    int          cycles = 0;

    // Reference model state
    logic        m_valid [8];
    cache_tag_t  m_tag [8];
    cache_data_t m_data [8];
    int          m_hits = 0;
    int          m_misses = 0;

    cache_top #(
        .KEY_INIT (128'h9a3c_51e7_0d48_b26f_c915_7e03_a6d2_4b8f)
    ) dut0 (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Line view: space, 3 reserved, tag, index, halfword bit
    function automatic logic [addr_w-1:0] line_addr(input int idx, input cache_tag_t tag);
        return {1'b0, 3'b000, tag, idx[2:0], 1'b0};
    endfunction

    function automatic logic [addr_w-1:0] csr_addr(input logic [1:0] sel);
        return {1'b1, 9'b0, sel};
    endfunction

    function automatic void push_entry(input logic wr, input logic [addr_w-1:0] addr,
                                       input cache_data_t wdata, input cache_data_t exp_data,
                                       input logic exp_err);
        entry_t e;
        e.wr       = wr;
        e.addr     = addr;
        e.wdata    = wdata;
        e.exp_data = exp_data;
        e.exp_err  = exp_err;
        tbl.push_back(e);
    endfunction

    function automatic void add_line_write(input int idx, input cache_tag_t tag,
                                           input cache_data_t data);
        m_valid[idx] = 1'b1;
        m_tag[idx]   = tag;
        m_data[idx]  = data;
        push_entry(1'b1, line_addr(idx, tag), data, '0, 1'b0);
    endfunction

    function automatic void add_line_read(input int idx, input cache_tag_t tag);
        if (m_valid[idx] && m_tag[idx] == tag) begin
            m_hits++;
            push_entry(1'b0, line_addr(idx, tag), '0, m_data[idx], 1'b0);
        end else begin
            m_misses++;  // Read miss answers with an error and zero data
            push_entry(1'b0, line_addr(idx, tag), '0, '0, 1'b1);
        end
    endfunction

    function automatic void add_csr_write(input logic [1:0] sel);
        if (sel == csr_flush) begin
            for (int i = 0; i < 8; i++) m_valid[i] = 1'b0;
        end
        push_entry(1'b1, csr_addr(sel), cache_data_t'(take_bits(16)), '0, sel == 2'd3);
    endfunction

    function automatic void add_csr_read(input logic [1:0] sel);
        cache_data_t exp;
        exp = '0;
        if (sel == csr_hits) exp = cache_data_t'(m_hits);
        if (sel == csr_misses) exp = cache_data_t'(m_misses);
        push_entry(1'b0, csr_addr(sel), '0, exp, sel == 2'd3);
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_data(input string name, input cache_data_t got, input cache_data_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    // One APB transfer, entered and left right after a rising edge
    task automatic apb_xfer(input logic wr, input logic [addr_w-1:0] addr,
                            input cache_data_t wdata, output cache_data_t rdata,
                            output logic err);
        int waits;
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        waits = 0;
        @(negedge clk);
        while (!pready) begin
            waits++;
            if (waits > 8) stop_with_failure("pready never rose during an APB transfer");
            @(negedge clk);
        end
        if (waits != 1) begin
            stop_with_failure($sformatf("transfer to address %h took %0d wait states, not one",
                                        addr, waits));
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
    endtask

    // Run limit grows with the table
    always @(posedge clk) begin
        cycles++;
        if (cycles >= tbl.size() * 3 + 20) begin
            stop_with_failure("timeout, the test table did not finish in time");
        end
    end

    initial begin
        cache_data_t got_data;
        logic        got_err;
        cache_tag_t  old_tag;

        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        rst     = 1'b1;
        for (int i = 0; i < 8; i++) begin
            m_valid[i] = 1'b0;
            m_tag[i]   = '0;
            m_data[i]  = '0;
        end

        // Cold cache, every read misses
        for (int i = 0; i < 8; i++) add_line_read(i, cache_tag_t'(take_bits(4)));
        add_csr_read(csr_misses);
        // Fill all lines, then read back through the scrambler
        for (int i = 0; i < 8; i++) begin
            add_line_write(i, cache_tag_t'(take_bits(4)), cache_data_t'(take_bits(16)));
        end
        for (int i = 0; i < 8; i++) add_line_read(i, m_tag[i]);
        // Tag mismatch and tag replacement
        add_line_read(2, m_tag[2] ^ 4'h1);
        old_tag = m_tag[5];
        add_line_write(5, old_tag ^ 4'h9, cache_data_t'(take_bits(16)));
        add_line_read(5, old_tag);
        add_line_read(5, m_tag[5]);
        // Flush drops everything
        add_csr_write(csr_flush);
        for (int i = 0; i < 8; i++) add_line_read(i, m_tag[i]);
        add_line_write(0, cache_tag_t'(take_bits(4)), cache_data_t'(take_bits(16)));
        add_line_write(7, cache_tag_t'(take_bits(4)), cache_data_t'(take_bits(16)));
        add_line_read(0, m_tag[0]);
        add_line_read(7, m_tag[7]);
        // Counter CSRs and the undefined select
        add_csr_read(csr_hits);
        add_csr_read(csr_misses);
        add_csr_read(2'd3);
        add_csr_write(2'd3);
        add_csr_read(csr_flush);

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        foreach (tbl[i]) begin
            apb_xfer(tbl[i].wr, tbl[i].addr, tbl[i].wdata, got_data, got_err);
            check_err($sformatf("pslverr[%0d]", i), got_err, tbl[i].exp_err);
            check_data($sformatf("prdata[%0d]", i), got_data, tbl[i].exp_data);
        end
        psel    <= 1'b0;
        penable <= 1'b0;
        @(posedge clk);

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- project.f
design/cache_pkg.sv
design/line_scrambler.sv
design/line_store.sv
design/cache_ctrl.sv
design/cache_top.sv
dv/cache_tb.sv
